// File: rv_pkg.sv
package rv_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;

  // Major opcodes of the base integer set.
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;
  localparam logic [6:0] OP_FENCE  = 7'b0001111;

  // ALU operation is {funct7[5], funct3}.
  localparam logic [3:0] ALU_ADD  = 4'b0000;
  localparam logic [3:0] ALU_SUB  = 4'b1000;
  localparam logic [3:0] ALU_SLL  = 4'b0001;
  localparam logic [3:0] ALU_SLT  = 4'b0010;
  localparam logic [3:0] ALU_SLTU = 4'b0011;
  localparam logic [3:0] ALU_XOR  = 4'b0100;
  localparam logic [3:0] ALU_SRL  = 4'b0101;
  localparam logic [3:0] ALU_SRA  = 4'b1101;
  localparam logic [3:0] ALU_OR   = 4'b0110;
  localparam logic [3:0] ALU_AND  = 4'b0111;

  localparam logic [2:0] BR_EQ  = 3'b000;
  localparam logic [2:0] BR_NE  = 3'b001;
  localparam logic [2:0] BR_LT  = 3'b100;
  localparam logic [2:0] BR_GE  = 3'b101;
  localparam logic [2:0] BR_LTU = 3'b110;
  localparam logic [2:0] BR_GEU = 3'b111;

  typedef logic [2:0] kind_t;

  localparam kind_t K_ALU     = 3'd0;
  localparam kind_t K_JUMP    = 3'd1;
  localparam kind_t K_BRANCH  = 3'd2;
  localparam kind_t K_LOAD    = 3'd3;
  localparam kind_t K_STORE   = 3'd4;
  localparam kind_t K_NOP     = 3'd5;
  localparam kind_t K_ILLEGAL = 3'd6;

  // One instruction word seen through each of the six encoding formats.
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r_fmt;
    struct packed {
      logic [11:0] imm_11_0;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i_fmt;
    struct packed {
      logic [6:0] imm_11_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_4_0;
      logic [6:0] opcode;
    } s_fmt;
    struct packed {
      logic       imm_12;
      logic [5:0] imm_10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm_4_1;
      logic       imm_11;
      logic [6:0] opcode;
    } b_fmt;
    struct packed {
      logic [19:0] imm_31_12;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } u_fmt;
    struct packed {
      logic       imm_20;
      logic [9:0] imm_10_1;
      logic       imm_11;
      logic [7:0] imm_19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
    } j_fmt;
  } inst_u_t;

endpackage

// File: rv_stage_if.sv
interface rv_stage_if;

  logic                          valid;
  logic                          ready;
  rv_pkg::kind_t                 kind;
  logic [3:0]                    alu_op;
  logic [rv_pkg::XLEN-1:0]       op1;
  logic [rv_pkg::XLEN-1:0]       op2;
  logic [rv_pkg::XLEN-1:0]       jbase;
  logic [rv_pkg::XLEN-1:0]       imm;
  logic [rv_pkg::XLEN-1:0]       rs2_data;
  logic [rv_pkg::REG_ADDR_W-1:0] rd;
  logic [rv_pkg::XLEN-1:0]       pc;

  // Decode side.
  modport src (
    output valid, kind, alu_op, op1, op2, jbase, imm, rs2_data, rd, pc,
    input  ready
  );

  // Execute side.
  modport dst (
    input  valid, kind, alu_op, op1, op2, jbase, imm, rs2_data, rd, pc,
    output ready
  );

endinterface

// File: rv_regfile.sv
module rv_regfile (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [rv_pkg::REG_ADDR_W-1:0] raddr1_i,
  input  logic [rv_pkg::REG_ADDR_W-1:0] raddr2_i,
  output logic [rv_pkg::XLEN-1:0]       rdata1_o,
  output logic [rv_pkg::XLEN-1:0]       rdata2_o,
  input  logic                          we_i,
  input  logic [rv_pkg::REG_ADDR_W-1:0] waddr_i,
  input  logic [rv_pkg::XLEN-1:0]       wdata_i
);

  // Register 0 has no storage.
  logic [rv_pkg::XLEN-1:0] regs [1:31];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
  assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

// File: rv_decode.sv
module rv_decode (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          inst_valid_i,
  input  logic [31:0]                   inst_i,
  input  logic [rv_pkg::XLEN-1:0]       pc_i,
  output logic                          inst_ready_o,
  output logic [rv_pkg::REG_ADDR_W-1:0] rs1_o,
  output logic [rv_pkg::REG_ADDR_W-1:0] rs2_o,
  input  logic [rv_pkg::XLEN-1:0]       rdata1_i,
  input  logic [rv_pkg::XLEN-1:0]       rdata2_i,
  rv_stage_if.src                       out
);

  rv_pkg::inst_u_t         inst_q;
  logic [rv_pkg::XLEN-1:0] pc_q;
  logic                    valid_q;
  logic                    accept;
  logic [6:0]              opcode;
  logic [2:0]              funct3;
  logic [rv_pkg::XLEN-1:0] imm_i;
  logic [rv_pkg::XLEN-1:0] imm_s;
  logic [rv_pkg::XLEN-1:0] imm_b;
  logic [rv_pkg::XLEN-1:0] imm_u;
  logic [rv_pkg::XLEN-1:0] imm_j;

  // The stage holds one instruction, so it is ready only when empty.
  assign inst_ready_o = !valid_q;
  assign accept       = inst_valid_i && inst_ready_o;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (accept) begin
      valid_q <= 1'b1;
    end else if (out.ready) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      inst_q <= inst_i;
      pc_q   <= pc_i;
    end
  end

  assign opcode = inst_q.r_fmt.opcode;
  assign funct3 = inst_q.r_fmt.funct3;
  assign rs1_o  = inst_q.r_fmt.rs1;
  assign rs2_o  = inst_q.r_fmt.rs2;

  assign imm_i = {{20{inst_q.i_fmt.imm_11_0[11]}}, inst_q.i_fmt.imm_11_0};
  assign imm_s = {{20{inst_q.s_fmt.imm_11_5[6]}}, inst_q.s_fmt.imm_11_5,
                  inst_q.s_fmt.imm_4_0};
  assign imm_b = {{19{inst_q.b_fmt.imm_12}}, inst_q.b_fmt.imm_12, inst_q.b_fmt.imm_11,
                  inst_q.b_fmt.imm_10_5, inst_q.b_fmt.imm_4_1, 1'b0};
  assign imm_u = {inst_q.u_fmt.imm_31_12, 12'b0};
  assign imm_j = {{11{inst_q.j_fmt.imm_20}}, inst_q.j_fmt.imm_20, inst_q.j_fmt.imm_19_12,
                  inst_q.j_fmt.imm_11, inst_q.j_fmt.imm_10_1, 1'b0};

  assign out.valid    = valid_q;
  assign out.pc       = pc_q;
  assign out.rs2_data = rdata2_i;

  always_comb begin
    out.kind   = rv_pkg::K_ILLEGAL;
    out.alu_op = rv_pkg::ALU_ADD;
    out.op1    = '0;
    out.op2    = '0;
    out.jbase  = '0;
    out.imm    = '0;
    out.rd     = '0;
    case (opcode)
      rv_pkg::OP_LUI: begin
        out.kind = rv_pkg::K_ALU;
        out.imm  = imm_u;
        out.op2  = imm_u;
        out.rd   = inst_q.u_fmt.rd;
      end
      rv_pkg::OP_AUIPC: begin
        out.kind = rv_pkg::K_ALU;
        out.imm  = imm_u;
        out.op1  = pc_q;
        out.op2  = imm_u;
        out.rd   = inst_q.u_fmt.rd;
      end
      rv_pkg::OP_JAL: begin
        // The ALU forms the link value pc + 4.
        out.kind  = rv_pkg::K_JUMP;
        out.imm   = imm_j;
        out.op1   = pc_q;
        out.op2   = 32'd4;
        out.jbase = pc_q;
        out.rd    = inst_q.j_fmt.rd;
      end
      rv_pkg::OP_JALR: begin
        out.kind  = rv_pkg::K_JUMP;
        out.imm   = imm_i;
        out.op1   = pc_q;
        out.op2   = 32'd4;
        out.jbase = rdata1_i;
        out.rd    = inst_q.i_fmt.rd;
      end
      rv_pkg::OP_BRANCH: begin
        out.kind   = rv_pkg::K_BRANCH;
        out.alu_op = {1'b0, funct3};
        out.imm    = imm_b;
        out.op1    = rdata1_i;
        out.op2    = rdata2_i;
        out.jbase  = pc_q;
      end
      rv_pkg::OP_IMM: begin
        // Only SRAI carries the funct7 modifier here because SUB has no immediate form.
        out.kind   = rv_pkg::K_ALU;
        out.alu_op = {(funct3 == 3'b101) ? inst_q.r_fmt.funct7[5] : 1'b0, funct3};
        out.imm    = imm_i;
        out.op1    = rdata1_i;
        out.op2    = imm_i;
        out.rd     = inst_q.i_fmt.rd;
      end
      rv_pkg::OP_REG: begin
        out.kind   = rv_pkg::K_ALU;
        out.alu_op = {inst_q.r_fmt.funct7[5], funct3};
        out.op1    = rdata1_i;
        out.op2    = rdata2_i;
        out.rd     = inst_q.r_fmt.rd;
      end
      rv_pkg::OP_LOAD: begin
        out.kind = rv_pkg::K_LOAD;
        out.imm  = imm_i;
        out.op1  = rdata1_i;
        out.op2  = imm_i;
        out.rd   = inst_q.i_fmt.rd;
      end
      rv_pkg::OP_STORE: begin
        out.kind = rv_pkg::K_STORE;
        out.imm  = imm_s;
        out.op1  = rdata1_i;
        out.op2  = imm_s;
      end
      rv_pkg::OP_SYSTEM, rv_pkg::OP_FENCE: begin
        out.kind = rv_pkg::K_NOP;
      end
      default: begin
        out.kind = rv_pkg::K_ILLEGAL;
      end
    endcase
  end

endmodule

// File: rv_execute.sv
module rv_execute (
  input  logic                          clk,
  input  logic                          rst,
  rv_stage_if.dst                       in,
  output logic                          rf_we_o,
  output logic [rv_pkg::REG_ADDR_W-1:0] rf_waddr_o,
  output logic [rv_pkg::XLEN-1:0]       rf_wdata_o,
  output logic                          retire_valid_o,
  input  logic                          retire_ready_i,
  output logic [rv_pkg::XLEN-1:0]       retire_pc_o,
  output logic [rv_pkg::REG_ADDR_W-1:0] retire_rd_o,
  output logic [rv_pkg::XLEN-1:0]       retire_value_o,
  output logic [rv_pkg::XLEN-1:0]       retire_next_pc_o,
  output rv_pkg::kind_t                 retire_kind_o
);

  logic                          take;
  logic [4:0]                    shamt;
  logic [rv_pkg::XLEN-1:0]       alu_res;
  logic                          cmp;
  logic                          taken;
  logic [rv_pkg::XLEN-1:0]       target;
  logic [rv_pkg::XLEN-1:0]       next_pc;
  logic [rv_pkg::XLEN-1:0]       value;
  logic [rv_pkg::REG_ADDR_W-1:0] ret_rd;

  // A draining retire slot can be refilled in the same cycle.
  assign in.ready = !retire_valid_o || retire_ready_i;
  assign take     = in.valid && in.ready;

  assign shamt = in.op2[4:0];

  always_comb begin
    case (in.alu_op)
      rv_pkg::ALU_SUB:  alu_res = in.op1 - in.op2;
      rv_pkg::ALU_SLL:  alu_res = in.op1 << shamt;
      rv_pkg::ALU_SLT:  alu_res = {31'b0, $signed(in.op1) < $signed(in.op2)};
      rv_pkg::ALU_SLTU: alu_res = {31'b0, in.op1 < in.op2};
      rv_pkg::ALU_XOR:  alu_res = in.op1 ^ in.op2;
      rv_pkg::ALU_SRL:  alu_res = in.op1 >> shamt;
      rv_pkg::ALU_SRA:  alu_res = $unsigned($signed(in.op1) >>> shamt);
      rv_pkg::ALU_OR:   alu_res = in.op1 | in.op2;
      rv_pkg::ALU_AND:  alu_res = in.op1 & in.op2;
      default:          alu_res = in.op1 + in.op2;
    endcase
  end

  // Branches carry funct3 in the low bits of alu_op.
  always_comb begin
    case (in.alu_op[2:0])
      rv_pkg::BR_EQ:  cmp = (in.op1 == in.op2);
      rv_pkg::BR_NE:  cmp = (in.op1 != in.op2);
      rv_pkg::BR_LT:  cmp = ($signed(in.op1) < $signed(in.op2));
      rv_pkg::BR_GE:  cmp = ($signed(in.op1) >= $signed(in.op2));
      rv_pkg::BR_LTU: cmp = (in.op1 < in.op2);
      rv_pkg::BR_GEU: cmp = (in.op1 >= in.op2);
      default:        cmp = 1'b0;
    endcase
  end

  assign taken  = (in.kind == rv_pkg::K_BRANCH) && cmp;
  assign target = in.jbase + in.imm;

  // JAL targets are already even, so clearing bit 0 serves both jumps.
  always_comb begin
    if (in.kind == rv_pkg::K_JUMP) begin
      next_pc = {target[rv_pkg::XLEN-1:1], 1'b0};
    end else if (taken) begin
      next_pc = target;
    end else begin
      next_pc = in.pc + 32'd4;
    end
  end

  always_comb begin
    value  = '0;
    ret_rd = in.rd;
    case (in.kind)
      rv_pkg::K_ALU, rv_pkg::K_JUMP, rv_pkg::K_LOAD: value = alu_res;
      rv_pkg::K_BRANCH: value = {31'b0, taken};
      rv_pkg::K_STORE: begin
        value  = alu_res;
        ret_rd = in.rs2_data[rv_pkg::REG_ADDR_W-1:0];
      end
      default: value = '0;
    endcase
  end

  assign rf_we_o    = take && ((in.kind == rv_pkg::K_ALU) || (in.kind == rv_pkg::K_JUMP));
  assign rf_waddr_o = in.rd;
  assign rf_wdata_o = alu_res;

  always_ff @(posedge clk) begin
    if (rst) begin
      retire_valid_o <= 1'b0;
    end else if (take) begin
      retire_valid_o <= 1'b1;
    end else if (retire_ready_i) begin
      retire_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      retire_pc_o      <= in.pc;
      retire_rd_o      <= ret_rd;
      retire_value_o   <= value;
      retire_next_pc_o <= next_pc;
      retire_kind_o    <= in.kind;
    end
  end

endmodule

// File: rv_core_top.sv
module rv_core_top (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          inst_valid_i,
  input  logic [31:0]                   inst_i,
  input  logic [rv_pkg::XLEN-1:0]       pc_i,
  output logic                          inst_ready_o,
  output logic                          retire_valid_o,
  input  logic                          retire_ready_i,
  output logic [rv_pkg::XLEN-1:0]       retire_pc_o,
  output logic [rv_pkg::REG_ADDR_W-1:0] retire_rd_o,
  output logic [rv_pkg::XLEN-1:0]       retire_value_o,
  output logic [rv_pkg::XLEN-1:0]       retire_next_pc_o,
  output rv_pkg::kind_t                 retire_kind_o
);

  logic [rv_pkg::REG_ADDR_W-1:0] rs1;
  logic [rv_pkg::REG_ADDR_W-1:0] rs2;
  logic [rv_pkg::XLEN-1:0]       rdata1;
  logic [rv_pkg::XLEN-1:0]       rdata2;
  logic                          rf_we;
  logic [rv_pkg::REG_ADDR_W-1:0] rf_waddr;
  logic [rv_pkg::XLEN-1:0]       rf_wdata;

  rv_stage_if stage_if ();

  rv_regfile i_rv_regfile (
    .clk      (clk),
    .rst      (rst),
    .raddr1_i (rs1),
    .raddr2_i (rs2),
    .rdata1_o (rdata1),
    .rdata2_o (rdata2),
    .we_i     (rf_we),
    .waddr_i  (rf_waddr),
    .wdata_i  (rf_wdata)
  );

  rv_decode i_rv_decode (
    .clk          (clk),
    .rst          (rst),
    .inst_valid_i (inst_valid_i),
    .inst_i       (inst_i),
    .pc_i         (pc_i),
    .inst_ready_o (inst_ready_o),
    .rs1_o        (rs1),
    .rs2_o        (rs2),
    .rdata1_i     (rdata1),
    .rdata2_i     (rdata2),
    .out          (stage_if.src)
  );

  rv_execute i_rv_execute (
    .clk              (clk),
    .rst              (rst),
    .in               (stage_if.dst),
    .rf_we_o          (rf_we),
    .rf_waddr_o       (rf_waddr),
    .rf_wdata_o       (rf_wdata),
    .retire_valid_o   (retire_valid_o),
    .retire_ready_i   (retire_ready_i),
    .retire_pc_o      (retire_pc_o),
    .retire_rd_o      (retire_rd_o),
    .retire_value_o   (retire_value_o),
    .retire_next_pc_o (retire_next_pc_o),
    .retire_kind_o    (retire_kind_o)
  );

endmodule

// File: tb_rv_core.sv
module tb_rv_core;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int RESET_CYCLES = 16;
  // Each term is the number of instructions that one test issues, in test order.
  localparam int N_INSTR = 63 + 16 + 72 + 24 + 24 + 55;
  localparam int TIMEOUT_CYCLES = 4 * (N_INSTR * 4) + RESET_CYCLES;

  typedef struct {
    logic [31:0]   pc;
    logic [4:0]    rd;
    logic [31:0]   value;
    logic [31:0]   next_pc;
    rv_pkg::kind_t kind;
    int            test;
  } retire_t;

  logic          clk = 1'b0;
  logic          rst;
  logic          inst_valid_i;
  logic [31:0]   inst_i;
  logic [31:0]   pc_i;
  logic          inst_ready_o;
  logic          retire_valid_o;
  logic          retire_ready_i = 1'b1;
  logic [31:0]   retire_pc_o;
  logic [4:0]    retire_rd_o;
  logic [31:0]   retire_value_o;
  logic [31:0]   retire_next_pc_o;
  rv_pkg::kind_t retire_kind_o;

  logic [31:0] regs_m [32];
  retire_t     exp_q [$];
  logic [31:0] pc_cur;
  logic [31:0] rng = 32'd21292;
  logic [31:0] stall_rng = 32'd21292;
  logic        stall_on = 1'b0;
  int          cur_test = 0;
  int          errors [6] = '{default: 0};
  string       names [6] = '{"arithmetic", "upper_jump", "branch", "load_store",
                             "x0_illegal", "backpressure"};
  int          cycles = 0;
  int          n_pass = 0;
  int          n_fail = 0;

  rv_core_top i_rv_core_top (
    .clk              (clk),
    .rst              (rst),
    .inst_valid_i     (inst_valid_i),
    .inst_i           (inst_i),
    .pc_i             (pc_i),
    .inst_ready_o     (inst_ready_o),
    .retire_valid_o   (retire_valid_o),
    .retire_ready_i   (retire_ready_i),
    .retire_pc_o      (retire_pc_o),
    .retire_rd_o      (retire_rd_o),
    .retire_value_o   (retire_value_o),
    .retire_next_pc_o (retire_next_pc_o),
    .retire_kind_o    (retire_kind_o)
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic logic [31:0] next_random();
    rng = xorshift(rng);
    return rng;
  endfunction

  function automatic logic [31:0] sext(input logic [31:0] v, input int bits);
    logic [31:0] s;
    s = v << (32 - bits);
    return $unsigned($signed(s) >>> (32 - bits));
  endfunction

  function automatic logic [4:0] pick_rd(input logic [3:0] v);
    return (v == 4'd0) ? 5'd1 : {1'b0, v};
  endfunction

  function automatic logic [31:0] alu_ref(input logic [3:0] op, input logic [31:0] a,
                                          input logic [31:0] b);
    case (op)
      rv_pkg::ALU_ADD:  return a + b;
      rv_pkg::ALU_SUB:  return a - b;
      rv_pkg::ALU_SLL:  return a << b[4:0];
      rv_pkg::ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      rv_pkg::ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
      rv_pkg::ALU_XOR:  return a ^ b;
      rv_pkg::ALU_SRL:  return a >> b[4:0];
      rv_pkg::ALU_SRA:  return $unsigned($signed(a) >>> b[4:0]);
      rv_pkg::ALU_OR:   return a | b;
      rv_pkg::ALU_AND:  return a & b;
      default:          return 32'd0;
    endcase
  endfunction

  function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
                                      input logic [31:0] b);
    case (f3)
      rv_pkg::BR_EQ:  return a == b;
      rv_pkg::BR_NE:  return a != b;
      rv_pkg::BR_LT:  return $signed(a) < $signed(b);
      rv_pkg::BR_GE:  return $signed(a) >= $signed(b);
      rv_pkg::BR_LTU: return a < b;
      default:        return a >= b;
    endcase
  endfunction

  // Records the expected retire, updates the model registers and hands the word to the DUT.
  task automatic send(input logic [31:0] word, input rv_pkg::kind_t kind, input logic [4:0] rd,
                      input logic [31:0] value, input logic [31:0] next_pc);
    retire_t r;
    r.pc = pc_cur;
    r.rd = rd;
    r.value = value;
    r.next_pc = next_pc;
    r.kind = kind;
    r.test = cur_test;
    exp_q.push_back(r);
    if ((kind == rv_pkg::K_ALU || kind == rv_pkg::K_JUMP) && rd != 5'd0) begin
      regs_m[rd] = value;
    end
    @(posedge clk);
    inst_valid_i <= 1'b1;
    inst_i <= word;
    pc_i <= pc_cur;
    @(negedge clk);
    while (!inst_ready_o) begin
      @(negedge clk);
    end
    @(posedge clk);
    inst_valid_i <= 1'b0;
    pc_cur = pc_cur + 32'd4;
  endtask

  task automatic alu_imm(input logic [2:0] f3, input logic mod, input logic [4:0] rd,
                         input logic [4:0] rs1, input logic [11:0] imm);
    rv_pkg::inst_u_t w;
    logic [11:0]     imm_enc;
    logic [31:0]     res;
    // Shift immediates carry only a shift amount and the arithmetic flag.
    imm_enc = (f3 == 3'b001 || f3 == 3'b101) ? {1'b0, mod, 5'b0, imm[4:0]} : imm;
    w = '0;
    w.i_fmt.imm_11_0 = imm_enc;
    w.i_fmt.rs1 = rs1;
    w.i_fmt.funct3 = f3;
    w.i_fmt.rd = rd;
    w.i_fmt.opcode = rv_pkg::OP_IMM;
    res = alu_ref({mod, f3}, regs_m[rs1], sext({20'b0, imm_enc}, 12));
    send(w, rv_pkg::K_ALU, rd, res, pc_cur + 32'd4);
  endtask

  task automatic alu_reg(input logic [2:0] f3, input logic mod, input logic [4:0] rd,
                         input logic [4:0] rs1, input logic [4:0] rs2);
    rv_pkg::inst_u_t w;
    logic [31:0]     res;
    w = '0;
    w.r_fmt.funct7 = {1'b0, mod, 5'b0};
    w.r_fmt.rs2 = rs2;
    w.r_fmt.rs1 = rs1;
    w.r_fmt.funct3 = f3;
    w.r_fmt.rd = rd;
    w.r_fmt.opcode = rv_pkg::OP_REG;
    res = alu_ref({mod, f3}, regs_m[rs1], regs_m[rs2]);
    send(w, rv_pkg::K_ALU, rd, res, pc_cur + 32'd4);
  endtask

  task automatic upper(input logic auipc, input logic [4:0] rd, input logic [19:0] imm);
    rv_pkg::inst_u_t w;
    w = '0;
    w.u_fmt.imm_31_12 = imm;
    w.u_fmt.rd = rd;
    w.u_fmt.opcode = auipc ? rv_pkg::OP_AUIPC : rv_pkg::OP_LUI;
    send(w, rv_pkg::K_ALU, rd, {imm, 12'b0} + (auipc ? pc_cur : 32'd0), pc_cur + 32'd4);
  endtask

  task automatic jal(input logic [4:0] rd, input logic [20:0] imm);
    rv_pkg::inst_u_t w;
    logic [31:0]     target;
    w = '0;
    w.j_fmt.imm_20 = imm[20];
    w.j_fmt.imm_10_1 = imm[10:1];
    w.j_fmt.imm_11 = imm[11];
    w.j_fmt.imm_19_12 = imm[19:12];
    w.j_fmt.rd = rd;
    w.j_fmt.opcode = rv_pkg::OP_JAL;
    target = pc_cur + sext({11'b0, imm[20:1], 1'b0}, 21);
    send(w, rv_pkg::K_JUMP, rd, pc_cur + 32'd4, target);
  endtask

  task automatic jalr(input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
    rv_pkg::inst_u_t w;
    logic [31:0]     target;
    w = '0;
    w.i_fmt.imm_11_0 = imm;
    w.i_fmt.rs1 = rs1;
    w.i_fmt.rd = rd;
    w.i_fmt.opcode = rv_pkg::OP_JALR;
    target = regs_m[rs1] + sext({20'b0, imm}, 12);
    send(w, rv_pkg::K_JUMP, rd, pc_cur + 32'd4, {target[31:1], 1'b0});
  endtask

  task automatic branch(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2,
                        input logic [12:0] imm);
    rv_pkg::inst_u_t w;
    logic            taken;
    w = '0;
    w.b_fmt.imm_12 = imm[12];
    w.b_fmt.imm_10_5 = imm[10:5];
    w.b_fmt.rs2 = rs2;
    w.b_fmt.rs1 = rs1;
    w.b_fmt.funct3 = f3;
    w.b_fmt.imm_4_1 = imm[4:1];
    w.b_fmt.imm_11 = imm[11];
    w.b_fmt.opcode = rv_pkg::OP_BRANCH;
    taken = branch_ref(f3, regs_m[rs1], regs_m[rs2]);
    send(w, rv_pkg::K_BRANCH, 5'd0, {31'b0, taken},
         taken ? pc_cur + sext({19'b0, imm[12:1], 1'b0}, 13) : pc_cur + 32'd4);
  endtask

  task automatic load(input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
    rv_pkg::inst_u_t w;
    w = '0;
    w.i_fmt.imm_11_0 = imm;
    w.i_fmt.rs1 = rs1;
    w.i_fmt.funct3 = 3'b010;
    w.i_fmt.rd = rd;
    w.i_fmt.opcode = rv_pkg::OP_LOAD;
    send(w, rv_pkg::K_LOAD, rd, regs_m[rs1] + sext({20'b0, imm}, 12), pc_cur + 32'd4);
  endtask

  task automatic store(input logic [4:0] rs1, input logic [4:0] rs2, input logic [11:0] imm);
    rv_pkg::inst_u_t w;
    w = '0;
    w.s_fmt.imm_11_5 = imm[11:5];
    w.s_fmt.rs2 = rs2;
    w.s_fmt.rs1 = rs1;
    w.s_fmt.funct3 = 3'b010;
    w.s_fmt.imm_4_0 = imm[4:0];
    w.s_fmt.opcode = rv_pkg::OP_STORE;
    // Store data shows up in the retire rd field.
    send(w, rv_pkg::K_STORE, regs_m[rs2][4:0], regs_m[rs1] + sext({20'b0, imm}, 12),
         pc_cur + 32'd4);
  endtask

  task automatic plain_word(input logic [31:0] word, input rv_pkg::kind_t kind);
    send(word, kind, 5'd0, 32'd0, pc_cur + 32'd4);
  endtask

  task automatic read_all();
    for (int i = 1; i < 16; i++) begin
      alu_imm(3'b000, 1'b0, 5'(i), 5'(i), 12'h000);
    end
  endtask

  task automatic random_alu(input int forced);
    logic [31:0] r;
    logic [2:0]  f3;
    logic        mod;
    logic        use_reg;
    r = next_random();
    f3 = r[2:0];
    use_reg = r[3];
    mod = r[4] && ((f3 == 3'b101) || (use_reg && (f3 == 3'b000)));
    // SUB, SRA, SLT and SLTU come first so each one is exercised.
    case (forced)
      0: {use_reg, mod, f3} = 5'b11000;
      1: {use_reg, mod, f3} = 5'b11101;
      2: {use_reg, mod, f3} = 5'b10010;
      3: {use_reg, mod, f3} = 5'b00011;
      default: ;
    endcase
    if (use_reg) begin
      alu_reg(f3, mod, pick_rd(r[8:5]), {1'b0, r[12:9]}, {1'b0, r[16:13]});
    end else begin
      alu_imm(f3, mod, pick_rd(r[8:5]), {1'b0, r[12:9]}, r[28:17]);
    end
  endtask

  task automatic arithmetic_mix();
    logic [31:0] r;
    for (int i = 1; i <= 8; i++) begin
      r = next_random();
      alu_imm(3'b000, 1'b0, 5'(i), 5'd0, r[11:0]);
    end
    for (int i = 0; i < 40; i++) begin
      random_alu(i);
    end
    read_all();
  endtask

  task automatic upper_and_jumps();
    logic [31:0] r;
    for (int i = 0; i < 4; i++) begin
      r = next_random();
      upper(1'b0, pick_rd(r[3:0]), r[31:12]);
      r = next_random();
      upper(1'b1, pick_rd(r[3:0]), r[31:12]);
      r = next_random();
      jal(pick_rd(r[3:0]), {r[31:12], 1'b0});
      r = next_random();
      jalr(pick_rd(r[3:0]), {1'b0, r[7:4]}, r[31:20]);
    end
  endtask

  task automatic branch_conditions();
    logic [31:0] r;
    logic [11:0] a;
    logic [11:0] b;
    for (int f = 0; f < 8; f++) begin
      if (f == 2 || f == 3) begin
        continue;
      end
      // Equal, same sign, opposite sign, then fully random operands.
      for (int c = 0; c < 4; c++) begin
        r = next_random();
        a = r[11:0];
        case (c)
          0: b = a;
          1: b = {a[11], r[22:12]};
          2: b = {~a[11], r[22:12]};
          default: b = r[23:12];
        endcase
        alu_imm(3'b000, 1'b0, 5'd1, 5'd0, a);
        alu_imm(3'b000, 1'b0, 5'd2, 5'd0, b);
        branch(f[2:0], 5'd1, 5'd2, r[31:19]);
      end
    end
  endtask

  task automatic memory_ops();
    logic [31:0] r;
    logic [4:0]  rd;
    for (int i = 0; i < 8; i++) begin
      r = next_random();
      rd = pick_rd(r[3:0]);
      load(rd, {1'b0, r[7:4]}, r[19:8]);
      alu_imm(3'b000, 1'b0, rd, rd, 12'h000);
      r = next_random();
      store({1'b0, r[3:0]}, {1'b0, r[7:4]}, r[19:8]);
    end
  endtask

  task automatic x0_and_illegal();
    logic [31:0] r;
    r = next_random();
    alu_imm(3'b000, 1'b0, 5'd0, 5'd0, r[11:0]);
    alu_reg(3'b000, 1'b0, 5'd0, 5'd1, 5'd2);
    alu_imm(3'b000, 1'b0, 5'd3, 5'd0, 12'h000);
    for (int i = 0; i < 4; i++) begin
      r = next_random();
      case (i)
        0: r[6:0] = 7'h00;
        1: r[6:0] = 7'h7f;
        2: r[6:0] = 7'h2f;
        default: r[6:0] = 7'h5b;
      endcase
      plain_word(r, rv_pkg::K_ILLEGAL);
    end
    r = next_random();
    plain_word({r[31:7], rv_pkg::OP_SYSTEM}, rv_pkg::K_NOP);
    r = next_random();
    plain_word({r[31:7], rv_pkg::OP_FENCE}, rv_pkg::K_NOP);
    read_all();
  endtask

  task automatic backpressure_mix();
    logic [31:0] r;
    logic [2:0]  f3;
    for (int i = 0; i < 40; i++) begin
      r = next_random();
      // Funct3 values 2 and 3 are not branches, so they fold onto LTU and GEU.
      f3 = (r[5:4] == 2'b01) ? {1'b1, r[4:3]} : r[5:3];
      case (r[2:0])
        3'd2: upper(r[3], pick_rd(r[7:4]), r[31:12]);
        3'd3: branch(f3, {1'b0, r[9:6]}, {1'b0, r[13:10]}, r[26:14]);
        3'd4: load(pick_rd(r[6:3]), {1'b0, r[10:7]}, r[22:11]);
        3'd5: store({1'b0, r[6:3]}, {1'b0, r[10:7]}, r[22:11]);
        3'd6: jal(pick_rd(r[6:3]), {r[26:7], 1'b0});
        default: random_alu(-1);
      endcase
    end
    read_all();
  endtask

  task automatic check_field(input int t, input string field, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
    assert (act_v === exp_v) else begin
      $display("FAILED %s %s expected %h actual %h", names[t], field, exp_v, act_v);
      errors[t]++;
    end
  endtask

  task automatic check_retire();
    retire_t e;
    assert (exp_q.size() > 0) else begin
      $display("A retire at pc %h arrived with no instruction outstanding", retire_pc_o);
      errors[cur_test]++;
    end
    if (exp_q.size() > 0) begin
      e = exp_q.pop_front();
      check_field(e.test, "pc", e.pc, retire_pc_o);
      check_field(e.test, "kind", e.kind, retire_kind_o);
      check_field(e.test, "rd", e.rd, retire_rd_o);
      check_field(e.test, "value", e.value, retire_value_o);
      check_field(e.test, "next_pc", e.next_pc, retire_next_pc_o);
    end
  endtask

  task automatic finish_test();
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (4) @(posedge clk);
    if (errors[cur_test] == 0) begin
      $display("Test %s: passed", names[cur_test]);
      n_pass++;
    end else begin
      $display("Test %s: failed with %0d errors", names[cur_test], errors[cur_test]);
      n_fail++;
    end
  endtask

  // A handshake seen at the falling edge completes at the next rising edge.
  always @(negedge clk) begin
    if (!rst && retire_valid_o && retire_ready_i) begin
      check_retire();
    end
  end

  retire_held: assert property (@(posedge clk) disable iff (rst)
    (retire_valid_o && !retire_ready_i) |=> (retire_valid_o && $stable(retire_pc_o) &&
      $stable(retire_rd_o) && $stable(retire_value_o) && $stable(retire_next_pc_o) &&
      $stable(retire_kind_o)))
  else begin
    $display("The retire record changed while retire_ready_i was low");
    errors[cur_test]++;
  end

  always @(posedge clk) begin
    if (stall_on) begin
      stall_rng = xorshift(stall_rng);
      retire_ready_i <= stall_rng[7];
    end else begin
      retire_ready_i <= 1'b1;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the DUT stopped making progress", cycles);
      $display("Something failed");
      $finish;
    end
  end

  initial begin
    rst = 1'b1;
    inst_valid_i = 1'b0;
    inst_i = '0;
    pc_i = '0;
    pc_cur = 32'h0000_1000;
    for (int i = 0; i < 32; i++) begin
      regs_m[i] = '0;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    cur_test = 0;
    arithmetic_mix();
    finish_test();
    cur_test = 1;
    upper_and_jumps();
    finish_test();
    cur_test = 2;
    branch_conditions();
    finish_test();
    cur_test = 3;
    memory_ops();
    finish_test();
    cur_test = 4;
    x0_and_illegal();
    finish_test();
    cur_test = 5;
    stall_on <= 1'b1;
    backpressure_mix();
    finish_test();
    stall_on <= 1'b0;
    $display("Tests passed: %0d, failed: %0d", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: rv_decode.f
rv_pkg.sv
rv_stage_if.sv
rv_regfile.sv
rv_decode.sv
rv_execute.sv
rv_core_top.sv
tb_rv_core.sv
